/* hw/fetch_consts.svh */
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// Fetch restarts here when reset is released
`define FETCH_RESET_PC 32'h1c00_0000

// Instruction words per fetch block
`define FETCH_WIDTH 2

// Instruction buffer entries, power of two so the pointers wrap on their own
`define IB_DEPTH 8

// Instruction and address width
`define WORD_W 32

`endif

/* hw/fetch_pkg.sv */
`include "fetch_consts.svh"

package fetch_pkg;

    // One machine word, used for PCs and instruction bits alike
    typedef logic [`WORD_W-1:0] word_t;

    // One bit per slot of a fetch block or commit group, slot 0 in bit 0
    typedef logic [`FETCH_WIDTH-1:0] slot_mask_t;

    // Holds 0 up to FETCH_WIDTH
    typedef logic [$clog2(`FETCH_WIDTH + 1)-1:0] pop_cnt_t;

    // Instruction tagged with the PC it was fetched from
    typedef struct packed {
        word_t pc;     // Upper half
        word_t instr;  // Lower half
    } instr_info_t;

endpackage

/* hw/fetch_unit.sv */
`include "fetch_consts.svh"

module fetch_unit
    import fetch_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_i,

    // Backend redirect
    input  logic                            redirect_i,
    input  word_t                           redirect_pc_i,

    // Buffer back-pressure
    input  logic                            ib_full_i,

    // Instruction memory port
    output logic                            fetch_req_o,
    output word_t                           fetch_addr_o,
    input  logic                            fetch_valid_i,
    input  word_t [`FETCH_WIDTH-1:0]        fetch_data_i,

    // Push side of the instruction buffer
    output slot_mask_t                      push_valid_o,
    output instr_info_t [`FETCH_WIDTH-1:0]  push_data_o
);

    localparam int BLOCK_BYTES = `FETCH_WIDTH * 4;
    localparam int OFS_W       = $clog2(BLOCK_BYTES);  // Byte offset bits within a block
    localparam int SLOT_W      = OFS_W - 2;            // Word index bits within a block

    word_t             pc_q;        // PC of the block being fetched, may sit mid-block
    logic              pending_q;   // A request is out and its data is not back yet
    logic              stale_q;     // Outstanding data belongs to a path left by a redirect
    logic              req_q;
    word_t             addr_q;

    word_t             block_base;
    logic [SLOT_W-1:0] first_slot;  // Word at which the block was entered
    logic              issue;
    logic              accept;

    assign block_base = {pc_q[`WORD_W-1:OFS_W], OFS_W'(0)};
    assign first_slot = pc_q[OFS_W-1:2];

    // Only one fetch in flight, and at least a full block of room in the buffer
    assign issue  = ~pending_q & ~ib_full_i & ~redirect_i;

    // Returned block goes into the buffer unless it is stale or about to be flushed
    assign accept = fetch_valid_i & pending_q & ~stale_q & ~redirect_i;

    assign fetch_req_o  = req_q;
    assign fetch_addr_o = addr_q;

    // Tag each word with its PC and drop the words before the entry point
    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            push_valid_o[i]      = accept && (i >= int'(first_slot));
            push_data_o[i].pc    = block_base + word_t'(4 * i);
            push_data_o[i].instr = fetch_data_i[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q      <= `FETCH_RESET_PC;
            pending_q <= 1'b0;
            stale_q   <= 1'b0;
            req_q     <= 1'b0;
        end else begin
            req_q <= issue;  // One-cycle request pulse

            if (fetch_valid_i && pending_q) begin
                pending_q <= 1'b0;
                stale_q   <= 1'b0;
                if (!stale_q) begin
                    pc_q <= block_base + word_t'(BLOCK_BYTES);  // Next sequential block
                end
            end else if (issue) begin
                pending_q <= 1'b1;
            end

            // Redirect wins over the sequential advance
            if (redirect_i) begin
                pc_q <= redirect_pc_i;
                if (pending_q && !fetch_valid_i) begin
                    stale_q <= 1'b1;  // Return still on its way, throw it away
                end
            end
        end
    end

    // Aligned request address, held for the whole request pulse
    always_ff @(posedge clk) begin
        if (issue) begin
            addr_q <= block_base;
        end
    end

endmodule

/* hw/instr_buffer.sv */
`include "fetch_consts.svh"

module instr_buffer
    import fetch_pkg::*;
#(
    parameter type payload_t = instr_info_t
) (
    input  logic                         clk,
    input  logic                         rst_i,
    input  logic                         flush_i,

    // Producer side
    input  slot_mask_t                   push_valid_i,
    input  payload_t [`FETCH_WIDTH-1:0]  push_data_i,
    output logic                         full_o,

    // Consumer side
    output slot_mask_t                   head_valid_o,
    output payload_t [`FETCH_WIDTH-1:0]  head_data_o,
    input  pop_cnt_t                     pop_count_i
);

    localparam int DEPTH = `IB_DEPTH;
    localparam int FW    = `FETCH_WIDTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem_q [DEPTH];

    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] free_cnt;

    logic [PTR_W-1:0] wr_ofs [FW];  // Slot position after packing out the empty slots
    pop_cnt_t         push_cnt;

    // Valid push slots are packed into consecutive entries
    always_comb begin
        push_cnt = '0;
        for (int i = 0; i < FW; i++) begin
            wr_ofs[i] = PTR_W'(push_cnt);  // Number of valid slots below this one
            if (push_valid_i[i]) begin
                push_cnt = push_cnt + pop_cnt_t'(1);
            end
        end
    end

    // Stall the producer once a whole block would no longer fit
    assign free_cnt = CNT_W'(DEPTH) - count_q;
    assign full_o   = free_cnt < CNT_W'(FW);

    // Oldest entries first
    always_comb begin
        for (int i = 0; i < FW; i++) begin
            head_valid_o[i] = count_q > CNT_W'(i);
            head_data_o[i]  = mem_q[rd_ptr_q + PTR_W'(i)];
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        for (int i = 0; i < FW; i++) begin
            if (push_valid_i[i]) begin
                mem_q[wr_ptr_q + wr_ofs[i]] <= push_data_i[i];
            end
        end
    end

    // Pointers wrap naturally since DEPTH is a power of two
    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            rd_ptr_q <= rd_ptr_q + PTR_W'(pop_count_i);
            wr_ptr_q <= wr_ptr_q + PTR_W'(push_cnt);
            count_q  <= count_q + CNT_W'(push_cnt) - CNT_W'(pop_count_i);
        end
    end

endmodule

/* hw/commit_stage.sv */
`include "fetch_consts.svh"

module commit_stage
    import fetch_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst_i,
    input  logic                            flush_i,
    input  logic                            stall_i,

    // Buffer head
    input  slot_mask_t                      head_valid_i,
    input  instr_info_t [`FETCH_WIDTH-1:0]  head_data_i,
    output pop_cnt_t                        pop_count_o,

    // Commit trace
    output slot_mask_t                      commit_valid_o,
    output word_t [`FETCH_WIDTH-1:0]        commit_pc_o,
    output word_t [`FETCH_WIDTH-1:0]        commit_instr_o
);

    slot_mask_t pop_mask;
    slot_mask_t valid_q;

    // Head valids are contiguous from slot 0, so the mask keeps program order
    assign pop_mask = stall_i ? '0 : head_valid_i;

    always_comb begin
        pop_count_o = '0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            pop_count_o = pop_count_o + pop_cnt_t'(pop_mask[i]);
        end
    end

    // Held group is shown once the stall drops
    assign commit_valid_o = valid_q & {`FETCH_WIDTH{~stall_i}};

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            valid_q <= '0;
        end else if (!stall_i) begin
            valid_q <= pop_mask;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                commit_pc_o[i]    <= head_data_i[i].pc;
                commit_instr_o[i] <= head_data_i[i].instr;
            end
        end
    end

endmodule

/* hw/fetch_top.sv */
`include "fetch_consts.svh"

module fetch_top
    import fetch_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_i,

    // Backend control
    input  logic                      redirect_i,
    input  word_t                     redirect_pc_i,
    input  logic                      stall_i,

    // Instruction memory port
    output logic                      fetch_req_o,
    output word_t                     fetch_addr_o,
    input  logic                      fetch_valid_i,
    input  word_t [`FETCH_WIDTH-1:0]  fetch_data_i,

    // Commit trace
    output slot_mask_t                commit_valid_o,
    output word_t [`FETCH_WIDTH-1:0]  commit_pc_o,
    output word_t [`FETCH_WIDTH-1:0]  commit_instr_o
);

    logic                            ib_full;
    slot_mask_t                      push_valid;
    instr_info_t [`FETCH_WIDTH-1:0]  push_data;
    slot_mask_t                      head_valid;
    instr_info_t [`FETCH_WIDTH-1:0]  head_data;
    pop_cnt_t                        pop_count;

    fetch_unit u_fetch_unit (
        .clk          (clk),
        .rst_i        (rst_i),
        .redirect_i   (redirect_i),
        .redirect_pc_i(redirect_pc_i),
        .ib_full_i    (ib_full),
        .fetch_req_o  (fetch_req_o),
        .fetch_addr_o (fetch_addr_o),
        .fetch_valid_i(fetch_valid_i),
        .fetch_data_i (fetch_data_i),
        .push_valid_o (push_valid),
        .push_data_o  (push_data)
    );

    instr_buffer #(
        .payload_t(instr_info_t)
    ) u_instr_buffer (
        .clk         (clk),
        .rst_i       (rst_i),
        .flush_i     (redirect_i),  // Empty at the edge after the redirect
        .push_valid_i(push_valid),
        .push_data_i (push_data),
        .full_o      (ib_full),
        .head_valid_o(head_valid),
        .head_data_o (head_data),
        .pop_count_i (pop_count)
    );

    commit_stage u_commit_stage (
        .clk           (clk),
        .rst_i         (rst_i),
        .flush_i       (redirect_i),
        .stall_i       (stall_i),
        .head_valid_i  (head_valid),
        .head_data_i   (head_data),
        .pop_count_o   (pop_count),
        .commit_valid_o(commit_valid_o),
        .commit_pc_o   (commit_pc_o),
        .commit_instr_o(commit_instr_o)
    );

endmodule

/* bench/tb_fetch_checker.sv */
`include "fetch_consts.svh"

module tb_fetch_checker
    import fetch_pkg::*;
#(
    parameter word_t PATTERN_KEY = '0
) (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      redirect_i,
    input  word_t                     redirect_pc_i,
    input  logic                      stall_i,
    input  logic                      fetch_req_i,
    input  word_t                     fetch_addr_i,
    input  logic                      fetch_valid_i,
    input  slot_mask_t                commit_valid_i,
    input  word_t [`FETCH_WIDTH-1:0]  commit_pc_i,
    input  word_t [`FETCH_WIDTH-1:0]  commit_instr_i,
    output logic                      fail_o
);

    timeunit 1ns;
    timeprecision 1ps;

    int    err_cnt = 0;
    word_t exp_pc;       // PC of the next instruction in program order
    logic  rst_d;
    logic  redir_d;      // Redirect seen at the previous edge
    logic  outstanding;  // Request seen, data not back yet

    assign fail_o = (err_cnt != 0);

    task automatic mismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        err_cnt++;
    endtask

    // All ports settle between edges, so everything is sampled at the rising edge
    always @(posedge clk) begin
        word_t slot_pc;
        int    n_valid;

        // From the first reset edge through the cycle after release
        if (rst_d) begin
            assert (commit_valid_i == '0)
                else mismatch("commit valid during or right after reset");
            assert (!fetch_req_i)
                else mismatch("fetch request during or right after reset");
        end

        if (rst_i) begin
            exp_pc      <= `FETCH_RESET_PC;
            redir_d     <= 1'b0;
            outstanding <= 1'b0;
        end else begin
            for (int i = 1; i < `FETCH_WIDTH; i++) begin
                assert (!commit_valid_i[i] || commit_valid_i[i-1])
                    else mismatch($sformatf("commit slot %0d valid without slot %0d", i, i - 1));
            end
            assert (!stall_i || commit_valid_i == '0)
                else mismatch($sformatf("commit valid %b while stalled", commit_valid_i));
            assert (!redir_d || commit_valid_i == '0)
                else mismatch($sformatf("commit valid %b right after redirect", commit_valid_i));

            // Reference model of the commit stream
            for (int i = 0; i < `FETCH_WIDTH; i++) begin
                if (commit_valid_i[i]) begin
                    slot_pc = exp_pc + word_t'(4 * i);
                    assert (commit_pc_i[i] == slot_pc)
                        else mismatch($sformatf("slot %0d PC %h, expected %h",
                                                i, commit_pc_i[i], slot_pc));
                    assert (commit_instr_i[i] == (slot_pc ^ PATTERN_KEY))
                        else mismatch($sformatf("slot %0d instr %h, expected %h", i,
                                                commit_instr_i[i], slot_pc ^ PATTERN_KEY));
                end
            end

            if (fetch_req_i) begin
                assert (!outstanding)
                    else mismatch("fetch request while another fetch is outstanding");
                assert (fetch_addr_i[2:0] == 3'b000)
                    else mismatch($sformatf("fetch address %h not 8-byte aligned", fetch_addr_i));
            end

            n_valid = $countones(commit_valid_i);
            if (redirect_i) begin
                exp_pc <= redirect_pc_i;  // New path from the next cycle on
            end else begin
                exp_pc <= exp_pc + word_t'(4 * n_valid);
            end
            outstanding <= (outstanding || fetch_req_i) && !fetch_valid_i;
            redir_d     <= redirect_i;
        end

        rst_d <= rst_i;
    end

endmodule

/* bench/tb_fetch_top.sv */
`include "fetch_consts.svh"

module tb_fetch_top
    import fetch_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    CLK_PERIOD         = 40;
    localparam int    RESET_CYCLES       = 8;
    localparam int    TIMEOUT_CYCLES     = 200;
    localparam int    SEQ_COMMITS        = 24;
    localparam int    STALL_CYCLES       = 24;  // Long enough to fill the buffer
    localparam int    POST_STALL_COMMITS = 12;
    localparam int    REDIR_COMMITS      = 10;
    localparam word_t PATTERN_KEY        = 32'h5a3c_96e1;
    localparam word_t REDIR_ALIGNED      = 32'h1c00_4000;
    localparam word_t REDIR_ODD          = 32'h1c00_8014;  // Bit 2 set

    logic                      clk;
    logic                      rst;
    logic                      redirect;
    word_t                     redirect_pc;
    logic                      stall;
    logic                      fetch_req;
    word_t                     fetch_addr;
    logic                      fetch_valid;
    word_t [`FETCH_WIDTH-1:0]  fetch_data;
    slot_mask_t                commit_valid;
    word_t [`FETCH_WIDTH-1:0]  commit_pc;
    word_t [`FETCH_WIDTH-1:0]  commit_instr;
    logic                      checker_fail;

    logic [7:0]                lfsr_q = 8'd24;

    fetch_top dut (
        .clk           (clk),
        .rst_i         (rst),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .stall_i       (stall),
        .fetch_req_o   (fetch_req),
        .fetch_addr_o  (fetch_addr),
        .fetch_valid_i (fetch_valid),
        .fetch_data_i  (fetch_data),
        .commit_valid_o(commit_valid),
        .commit_pc_o   (commit_pc),
        .commit_instr_o(commit_instr)
    );

    tb_fetch_checker #(
        .PATTERN_KEY(PATTERN_KEY)
    ) u_checker (
        .clk           (clk),
        .rst_i         (rst),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .stall_i       (stall),
        .fetch_req_i   (fetch_req),
        .fetch_addr_i  (fetch_addr),
        .fetch_valid_i (fetch_valid),
        .commit_valid_i(commit_valid),
        .commit_pc_i   (commit_pc),
        .commit_instr_i(commit_instr),
        .fail_o        (checker_fail)
    );

    // 8-bit Fibonacci LFSR, taps 8 6 5 4
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    // Memory latency of 1 to 4 cycles, one LFSR step per bit
    task automatic draw_latency(output int lat);
        lat = 1;
        for (int b = 0; b < 2; b++) begin
            lfsr_q = lfsr_next(lfsr_q);
            lat    = lat + (int'(lfsr_q[0]) << b);
        end
    endtask

    function automatic word_t pattern_word(input word_t addr);
        return addr ^ PATTERN_KEY;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // Advance to the next falling edge and stop on a checker error
    task automatic next_cycle();
        @(negedge clk);
        if (checker_fail) fail_run("stopping after a checker mismatch");
    endtask

    task automatic wait_commits(input int target, input string what);
        int seen;
        int cycles;

        seen   = 0;
        cycles = 0;
        while (seen < target && cycles < TIMEOUT_CYCLES) begin
            next_cycle();
            seen += $countones(commit_valid);
            cycles++;
        end
        if (seen < target) fail_run({"timed out waiting for ", what});
    endtask

    task automatic wait_request(input string what);
        int cycles;

        cycles = 0;
        next_cycle();
        while (!fetch_req && cycles < TIMEOUT_CYCLES) begin
            next_cycle();
            cycles++;
        end
        if (!fetch_req) fail_run({"timed out waiting for ", what});
    endtask

    task automatic send_redirect(input word_t target);
        redirect    = 1'b1;
        redirect_pc = target;
        next_cycle();
        redirect    = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Instruction memory, one block in flight
    initial begin
        int    wait_cnt;
        word_t blk_addr;
        logic  busy;

        fetch_valid = 1'b0;
        fetch_data  = '0;
        wait_cnt    = 0;
        blk_addr    = '0;
        busy        = 1'b0;
        forever begin
            @(negedge clk);
            fetch_valid = 1'b0;
            if (busy) begin
                if (wait_cnt > 1) begin
                    wait_cnt--;
                end else begin
                    busy        = 1'b0;
                    fetch_valid = 1'b1;
                    for (int w = 0; w < `FETCH_WIDTH; w++) begin
                        fetch_data[w] = pattern_word(blk_addr + word_t'(4 * w));
                    end
                end
            end else if (fetch_req) begin
                blk_addr = fetch_addr;
                draw_latency(wait_cnt);
                busy = 1'b1;
            end
        end
    end

    initial begin
        rst         = 1'b1;
        redirect    = 1'b0;
        redirect_pc = '0;
        stall       = 1'b0;
        repeat (RESET_CYCLES) next_cycle();
        rst = 1'b0;

        wait_commits(SEQ_COMMITS, "sequential commits");

        // Back-pressure through a full buffer
        stall = 1'b1;
        repeat (STALL_CYCLES) next_cycle();
        stall = 1'b0;
        wait_commits(POST_STALL_COMMITS, "commits after the stall release");

        // Redirect with a fetch in flight
        wait_request("a fetch request before the aligned redirect");
        send_redirect(REDIR_ALIGNED);
        wait_commits(REDIR_COMMITS, "commits after the aligned redirect");

        wait_request("a fetch request before the unaligned redirect");
        send_redirect(REDIR_ODD);
        wait_commits(REDIR_COMMITS, "commits after the unaligned redirect");

        repeat (4) next_cycle();
        if (checker_fail) begin
            fail_run("checker reported a mismatch");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

/* flist.f */
+incdir+hw
hw/fetch_pkg.sv
hw/fetch_unit.sv
hw/instr_buffer.sv
hw/commit_stage.sv
hw/fetch_top.sv
bench/tb_fetch_checker.sv
bench/tb_fetch_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fetch_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= Result: PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
